//--- eth_pkg.sv
// Ethernet MAC shared types
`default_nettype none

package eth_pkg;

    // One byte beat of a frame stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        // Bad frame or abort marker
        logic       user;
    } axis_byte_t;

    // One GMII byte clock cycle
    typedef struct packed {
        logic [7:0] d;
        logic       en;
        logic       er;
    } gmii_t;

    // Single cycle FIFO event pulses
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_PAYLOAD,
        TX_PAD,
        TX_FCS,
        TX_IFG
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_PAYLOAD,
        RX_DROP
    } rx_state_t;

    localparam logic [7:0] ETH_PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] ETH_SFD_BYTE = 8'hD5;
    localparam int ETH_PREAMBLE_LEN = 7;

    // Residue in normal bit order after data plus good FCS
    localparam logic [31:0] ETH_CRC_RESIDUE = 32'hC704DD7B;
    localparam logic [31:0] ETH_CRC_INIT = 32'hFFFFFFFF;
    // Reflected form of the 802.3 polynomial
    localparam logic [31:0] ETH_CRC_POLY = 32'hEDB88320;

    // Advance the reflected CRC-32 register by one byte, LSB first
    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ ETH_CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

`default_nettype wire

//--- eth_frame_fifo.sv
// Store and forward frame FIFO
`timescale 1ns/1ps
`default_nettype none

module eth_frame_fifo
    import eth_pkg::*;
#(
    parameter int ADDR_WIDTH = 12,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  wire logic         logic_clk,
    input  wire logic         logic_rst,
    input  wire axis_byte_t   s,
    input  wire logic         s_valid,
    output logic              s_ready,
    output axis_byte_t        m,
    output logic              m_valid,
    input  wire logic         m_ready,
    output fifo_status_t      status
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Each entry holds last flag and data byte
    logic [8:0] mem [DEPTH];
    logic [8:0] mem_q;

    // Extra MSB tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] wr_ptr_commit;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic drop_frame;
    logic active;
    logic full;
    logic full_cur;
    logic empty;
    logic s_take;
    logic discard;
    logic wr_en;
    logic rd_en;

    // Whole RAM taken, committed or not
    assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    // Current frame alone fills the RAM, it can never fit
    assign full_cur = (wr_ptr[ADDR_WIDTH] != wr_ptr_commit[ADDR_WIDTH]) &&
                      (wr_ptr[ADDR_WIDTH-1:0] == wr_ptr_commit[ADDR_WIDTH-1:0]);
    // Reader sees committed frames only
    assign empty = (rd_ptr == wr_ptr_commit);

    // Stall on full unless the frame is already lost
    assign s_ready = active && (DROP_WHEN_FULL || !full || full_cur || drop_frame);
    assign s_take = s_valid && s_ready;
    // Full also covers a current frame that fills the RAM by itself
    assign discard = drop_frame || full;
    assign wr_en = s_take && !discard;

    // Input held off until out of reset
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // Write side and commit
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr <= '0;
            wr_ptr_commit <= '0;
            drop_frame <= 1'b0;
            status <= '0;
        end else begin
            status <= '0;
            if (s_take) begin
                if (discard) begin
                    // Roll back and swallow the rest of the frame
                    wr_ptr <= wr_ptr_commit;
                    drop_frame <= !s.last;
                    status.overflow <= s.last;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (s.last) begin
                        if (s.user) begin
                            wr_ptr <= wr_ptr_commit;
                            status.bad_frame <= 1'b1;
                        end else begin
                            wr_ptr_commit <= wr_ptr + 1'b1;
                            status.good_frame <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= {s.last, s.data};
        end
    end

    // Refill output register when empty or taken
    assign rd_en = !empty && (!m_valid || m_ready);
    assign mem_q = mem[rd_ptr[ADDR_WIDTH-1:0]];

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr <= '0;
            m_valid <= 1'b0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    // Stored frames are good ones, user goes out clear
    always_ff @(posedge logic_clk) begin
        if (rd_en) begin
            m.data <= mem_q[7:0];
            m.last <= mem_q[8];
            m.user <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- eth_mac_tx.sv
// GMII frame transmitter
`timescale 1ns/1ps
`default_nettype none

module eth_mac_tx
    import eth_pkg::*;
#(
    parameter bit ENABLE_PADDING = 1'b1,
    parameter int MIN_FRAME_LENGTH = 64
) (
    input  wire logic        logic_clk,
    input  wire logic        logic_rst,
    input  wire axis_byte_t  s,
    input  wire logic        s_valid,
    output logic             s_ready,
    output gmii_t            gmii,
    input  wire logic [7:0]  ifg_delay
);

    // Minimum payload, FCS not counted
    localparam logic [15:0] MIN_PAYLOAD = 16'(MIN_FRAME_LENGTH - 4);
    localparam logic [15:0] PREAMBLE_LEN = 16'(ETH_PREAMBLE_LEN);

    tx_state_t state;
    // Shared counter for preamble, payload, FCS and gap
    logic [15:0] cnt;
    logic [31:0] crc;
    axis_byte_t data_q;
    logic [7:0] fcs_byte;

    // FCS goes out inverted, low byte first
    assign fcs_byte = ~crc[8*cnt[1:0] +: 8];

    // First byte taken in idle, rest one per payload cycle
    assign s_ready = (state == TX_IDLE) || ((state == TX_PAYLOAD) && !data_q.last);

    // Byte staged for the next payload cycle
    always_ff @(posedge logic_clk) begin
        if (s_valid && s_ready) begin
            data_q <= s;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state <= TX_IDLE;
            cnt <= '0;
            crc <= ETH_CRC_INIT;
            gmii <= '0;
        end else begin
            // No error generation on transmit
            gmii.er <= 1'b0;
            case (state)
                TX_IDLE: begin
                    gmii.d <= 8'h00;
                    gmii.en <= 1'b0;
                    if (s_valid) begin
                        // First preamble byte already on the wire
                        gmii.d <= ETH_PREAMBLE_BYTE;
                        gmii.en <= 1'b1;
                        cnt <= 16'd1;
                        crc <= ETH_CRC_INIT;
                        state <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE: begin
                    if (cnt < PREAMBLE_LEN) begin
                        gmii.d <= ETH_PREAMBLE_BYTE;
                        cnt <= cnt + 16'd1;
                    end else begin
                        gmii.d <= ETH_SFD_BYTE;
                        cnt <= '0;
                        state <= TX_PAYLOAD;
                    end
                end
                TX_PAYLOAD: begin
                    // Frame is complete in the FIFO, so no underrun here
                    gmii.d <= data_q.data;
                    crc <= crc32_step(crc, data_q.data);
                    cnt <= cnt + 16'd1;
                    if (data_q.last) begin
                        if (ENABLE_PADDING && (cnt + 16'd1 < MIN_PAYLOAD)) begin
                            state <= TX_PAD;
                        end else begin
                            cnt <= '0;
                            state <= TX_FCS;
                        end
                    end
                end
                TX_PAD: begin
                    // Zero fill, still covered by the FCS
                    gmii.d <= 8'h00;
                    crc <= crc32_step(crc, 8'h00);
                    cnt <= cnt + 16'd1;
                    if (cnt + 16'd1 >= MIN_PAYLOAD) begin
                        cnt <= '0;
                        state <= TX_FCS;
                    end
                end
                TX_FCS: begin
                    gmii.d <= fcs_byte;
                    cnt <= cnt + 16'd1;
                    if (cnt[1:0] == 2'd3) begin
                        cnt <= '0;
                        state <= TX_IFG;
                    end
                end
                TX_IFG: begin
                    // Idle bytes for the programmed gap
                    gmii.d <= 8'h00;
                    gmii.en <= 1'b0;
                    cnt <= cnt + 16'd1;
                    if (cnt + 16'd1 >= {8'h00, ifg_delay}) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- eth_mac_rx.sv
// GMII frame receiver
`timescale 1ns/1ps
`default_nettype none

module eth_mac_rx
    import eth_pkg::*;
(
    input  wire logic   logic_clk,
    input  wire logic   logic_rst,
    input  wire gmii_t  gmii,
    output axis_byte_t  m,
    output logic        m_valid,
    output logic        bad_frame,
    output logic        bad_fcs
);

    rx_state_t state;

    // Newest byte in sr[0], sr[4] is five bytes old
    logic [4:0][7:0] sr;
    // Bytes held since the delimiter, saturates at 5
    logic [2:0] fill;
    logic [31:0] crc;
    logic [31:0] crc_norm;
    logic crc_bad;
    // er seen during the frame
    logic err;
    logic beat_valid;
    logic beat_last;

    // Reflected register back to normal order for the residue check
    assign crc_norm = {<<{crc}};
    assign crc_bad = (crc_norm != ETH_CRC_RESIDUE);

    // Oldest byte is payload once four more bytes follow it
    always_comb begin
        beat_valid = 1'b0;
        beat_last = 1'b0;
        if (state == RX_PAYLOAD) begin
            beat_valid = (fill == 3'd5);
            // en low means the four held bytes were the FCS
            beat_last = !gmii.en;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (gmii.en) begin
            sr <= {sr[3:0], gmii.d};
        end
        if (beat_valid) begin
            m.data <= sr[4];
            m.last <= beat_last;
            m.user <= beat_last && (err || crc_bad);
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state <= RX_IDLE;
            fill <= '0;
            crc <= ETH_CRC_INIT;
            err <= 1'b0;
            m_valid <= 1'b0;
            bad_frame <= 1'b0;
            bad_fcs <= 1'b0;
        end else begin
            m_valid <= beat_valid;
            bad_frame <= 1'b0;
            bad_fcs <= 1'b0;
            // Fresh frame state until the delimiter is past
            if (state != RX_PAYLOAD) begin
                fill <= '0;
                crc <= ETH_CRC_INIT;
                err <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    if (gmii.en) begin
                        if (gmii.d == ETH_SFD_BYTE) begin
                            state <= RX_PAYLOAD;
                        end else if (gmii.d == ETH_PREAMBLE_BYTE) begin
                            state <= RX_PREAMBLE;
                        end else begin
                            state <= RX_DROP;
                        end
                    end
                end
                RX_PREAMBLE: begin
                    if (!gmii.en) begin
                        state <= RX_IDLE;
                    end else if (gmii.d == ETH_SFD_BYTE) begin
                        state <= RX_PAYLOAD;
                    end else if (gmii.d != ETH_PREAMBLE_BYTE) begin
                        state <= RX_DROP;
                    end
                end
                RX_PAYLOAD: begin
                    if (gmii.en) begin
                        // CRC runs over payload and FCS alike
                        crc <= crc32_step(crc, gmii.d);
                        err <= err || gmii.er;
                        if (fill != 3'd5) begin
                            fill <= fill + 3'd1;
                        end
                    end else begin
                        state <= RX_IDLE;
                        // Runt with no payload counts as a bad frame
                        bad_frame <= err || (fill != 3'd5);
                        bad_fcs <= (fill == 3'd5) && crc_bad;
                    end
                end
                RX_DROP: begin
                    if (!gmii.en) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- eth_mac_fifo.sv
// Ethernet MAC with frame FIFOs
`timescale 1ns/1ps
`default_nettype none

module eth_mac_fifo
    import eth_pkg::*;
#(
    parameter bit ENABLE_PADDING = 1'b1,
    parameter int MIN_FRAME_LENGTH = 64,
    parameter int TX_FIFO_ADDR_WIDTH = 12,
    parameter int RX_FIFO_ADDR_WIDTH = 12
) (
    input  wire logic        logic_clk,
    input  wire logic        logic_rst,
    // Transmit frames in
    input  wire axis_byte_t  s_tx,
    input  wire logic        s_tx_valid,
    output logic             s_tx_ready,
    // Received frames out
    output axis_byte_t       m_rx,
    output logic             m_rx_valid,
    input  wire logic        m_rx_ready,
    // GMII, byte clock is logic_clk
    input  wire gmii_t       gmii_rx,
    output gmii_t            gmii_tx,
    // Status pulses
    output fifo_status_t     tx_fifo_status,
    output fifo_status_t     rx_fifo_status,
    output logic             rx_error_bad_frame,
    output logic             rx_error_bad_fcs,
    input  wire logic [7:0]  ifg_delay
);

    // Committed frames toward the transmitter
    axis_byte_t tx_mid;
    logic tx_mid_valid;
    logic tx_mid_ready;

    // Receiver output, cannot be stalled
    axis_byte_t rx_mid;
    logic rx_mid_valid;

    // Back-pressures the host instead of dropping
    eth_frame_fifo #(
        .ADDR_WIDTH(TX_FIFO_ADDR_WIDTH),
        .DROP_WHEN_FULL(1'b0)
    ) tx_fifo (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .s(s_tx),
        .s_valid(s_tx_valid),
        .s_ready(s_tx_ready),
        .m(tx_mid),
        .m_valid(tx_mid_valid),
        .m_ready(tx_mid_ready),
        .status(tx_fifo_status)
    );

    eth_mac_tx #(
        .ENABLE_PADDING(ENABLE_PADDING),
        .MIN_FRAME_LENGTH(MIN_FRAME_LENGTH)
    ) mac_tx (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .s(tx_mid),
        .s_valid(tx_mid_valid),
        .s_ready(tx_mid_ready),
        .gmii(gmii_tx),
        .ifg_delay(ifg_delay)
    );

    eth_mac_rx mac_rx (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .gmii(gmii_rx),
        .m(rx_mid),
        .m_valid(rx_mid_valid),
        .bad_frame(rx_error_bad_frame),
        .bad_fcs(rx_error_bad_fcs)
    );

    // Drops frames that do not fit, ready always high
    eth_frame_fifo #(
        .ADDR_WIDTH(RX_FIFO_ADDR_WIDTH),
        .DROP_WHEN_FULL(1'b1)
    ) rx_fifo (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .s(rx_mid),
        .s_valid(rx_mid_valid),
        .s_ready(),
        .m(m_rx),
        .m_valid(m_rx_valid),
        .m_ready(m_rx_ready),
        .status(rx_fifo_status)
    );

endmodule

`default_nettype wire

//--- tb_eth_mac_fifo.sv
// Ethernet MAC loopback testbench
`timescale 1ns/1ps
`default_nettype none

module tb_eth_mac_fifo
    import eth_pkg::*;
();

    localparam int MIN_FRAME = 64;
    localparam int MIN_PAYLOAD = MIN_FRAME - 4;
    localparam int FIFO_AW = 8;
    localparam int WAIT_LIMIT = 5000;
    // Wire byte index 10 is payload byte 2
    localparam int CORRUPT_INDEX = 10;
    // Slots in the pulse counter array
    localparam int P_TX_BAD = 0;
    localparam int P_TX_OVER = 1;
    localparam int P_RX_GOOD = 2;
    localparam int P_RX_BAD = 3;
    localparam int P_RX_OVER = 4;
    localparam int P_ERR_FRAME = 5;
    localparam int P_ERR_FCS = 6;
    localparam int P_TX_GOOD = 7;

    logic logic_clk = 1'b0;
    logic logic_rst;
    axis_byte_t s_tx;
    logic s_tx_valid;
    logic s_tx_ready;
    axis_byte_t m_rx;
    logic m_rx_valid;
    logic m_rx_ready;
    gmii_t gmii_rx = '0;
    gmii_t gmii_tx;
    fifo_status_t tx_fifo_status;
    fifo_status_t rx_fifo_status;
    logic rx_error_bad_frame;
    logic rx_error_bad_fcs;
    logic [7:0] ifg_delay;

    logic corrupt;
    logic [7:0] lb_cnt = '0;
    integer seed = 32'h2fe236f7;
    int pulse_cnt [8] = '{0, 0, 0, 0, 0, 0, 0, 0};
    // Expected wire bytes and frame lengths, in order
    logic [7:0] exp_wire [$];
    int exp_wire_len [$];
    // Expected m_rx beats as {last, data}
    logic [8:0] exp_rx [$];
    logic [8:0] rx_beat_exp;
    // GMII monitor state, updated on the falling edge
    logic wire_en_q = 1'b0;
    logic frame_seen = 1'b0;
    int frame_len = 0;
    int gap_len = 0;

    eth_mac_fifo #(
        .ENABLE_PADDING(1'b1),
        .MIN_FRAME_LENGTH(MIN_FRAME),
        .TX_FIFO_ADDR_WIDTH(FIFO_AW),
        .RX_FIFO_ADDR_WIDTH(FIFO_AW)
    ) DUT (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .s_tx(s_tx),
        .s_tx_valid(s_tx_valid),
        .s_tx_ready(s_tx_ready),
        .m_rx(m_rx),
        .m_rx_valid(m_rx_valid),
        .m_rx_ready(m_rx_ready),
        .gmii_rx(gmii_rx),
        .gmii_tx(gmii_tx),
        .tx_fifo_status(tx_fifo_status),
        .rx_fifo_status(rx_fifo_status),
        .rx_error_bad_frame(rx_error_bad_frame),
        .rx_error_bad_fcs(rx_error_bad_fcs),
        .ifg_delay(ifg_delay)
    );

    always #5 logic_clk = ~logic_clk;

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout, %s", what);
        stop_on_error();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic expect_pulses(input int idx, input int exp, input string name);
        check_value(name, pulse_cnt[idx], exp);
    endtask

    // Normal bit order CRC-32, data bits fed LSB first as on the wire
    function automatic logic [31:0] crc_normal_byte(input logic [31:0] crc,
                                                    input logic [7:0] b);
        logic [31:0] c;
        logic fb;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            fb = c[31] ^ b[k];
            c = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ 32'h04C11DB7;
            end
        end
        return c;
    endfunction

    function automatic logic [31:0] bit_reverse32(input logic [31:0] v);
        logic [31:0] r;
        for (int k = 0; k < 32; k++) begin
            r[k] = v[31 - k];
        end
        return r;
    endfunction

    // Hold one beat until taken, ready sampled mid cycle
    task automatic drive_beat(input axis_byte_t beat);
        int cycles;
        logic taken;
        cycles = 0;
        taken = 1'b0;
        s_tx <= beat;
        s_tx_valid <= 1'b1;
        while (!taken) begin
            @(negedge logic_clk);
            taken = s_tx_ready;
            @(posedge logic_clk);
            cycles++;
            if (!taken && cycles > WAIT_LIMIT) begin
                report_timeout("s_tx_ready stayed low");
            end
        end
    endtask

    // Random payload, expected wire and m_rx bytes queued first
    task automatic send_frame(input int len, input bit user_last, input bit expect_rx);
        logic [7:0] payload [$];
        logic [31:0] rnd;
        logic [31:0] crc;
        logic [31:0] fcs;
        logic [7:0] b;
        axis_byte_t beat;
        int padded;
        payload = {};
        for (int i = 0; i < len; i++) begin
            rnd = $random(seed);
            payload.push_back(rnd[7:0]);
        end
        padded = (len < MIN_PAYLOAD) ? MIN_PAYLOAD : len;
        if (!user_last) begin
            crc = 32'hFFFFFFFF;
            for (int i = 0; i < 7; i++) begin
                exp_wire.push_back(8'h55);
            end
            exp_wire.push_back(8'hD5);
            for (int i = 0; i < padded; i++) begin
                b = (i < len) ? payload[i] : 8'h00;
                crc = crc_normal_byte(crc, b);
                exp_wire.push_back(b);
                if (expect_rx) begin
                    exp_rx.push_back({(i == padded - 1), b});
                end
            end
            // Complemented remainder, x^31 term goes out first
            fcs = bit_reverse32(~crc);
            for (int i = 0; i < 4; i++) begin
                exp_wire.push_back(fcs[8*i +: 8]);
            end
            exp_wire_len.push_back(8 + padded + 4);
        end
        for (int i = 0; i < len; i++) begin
            beat.data = payload[i];
            beat.last = (i == len - 1);
            beat.user = user_last && (i == len - 1);
            drive_beat(beat);
        end
        s_tx_valid <= 1'b0;
    endtask

    task automatic wait_frames_done();
        int cycles;
        cycles = 0;
        while (exp_wire.size() != 0 || exp_rx.size() != 0 || wire_en_q) begin
            @(posedge logic_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout("frames did not drain through the MAC");
            end
        end
    endtask

    task automatic wait_for_count(input int idx, input int target, input string what);
        int cycles;
        cycles = 0;
        while (pulse_cnt[idx] < target) begin
            @(posedge logic_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout(what);
            end
        end
    endtask

    // PHY loopback with one cycle delay, optional byte flip
    always @(posedge logic_clk) begin
        lb_cnt <= gmii_tx.en ? lb_cnt + 8'd1 : 8'd0;
        gmii_rx <= gmii_tx;
        if (corrupt && gmii_tx.en && lb_cnt == CORRUPT_INDEX) begin
            gmii_rx.d <= ~gmii_tx.d;
        end
    end

    // Wire bytes, frame length and inter-frame gap
    always @(negedge logic_clk) begin
        if (!logic_rst) begin
            check_value("gmii_tx.er", gmii_tx.er, 1'b0);
            if (gmii_tx.en) begin
                if (!wire_en_q && frame_seen) begin
                    assert (gap_len >= ifg_delay) else begin
                        $display("FAILED gmii_tx.en gap: got %h, expected at least %h",
                                 gap_len, ifg_delay);
                        stop_on_error();
                    end
                end
                if (exp_wire.size() == 0) begin
                    $display("A GMII frame started with no frame expected");
                    stop_on_error();
                end else begin
                    check_value("gmii_tx.d", gmii_tx.d, exp_wire.pop_front());
                end
                frame_len++;
                gap_len = 0;
            end else begin
                if (wire_en_q) begin
                    check_value("gmii_tx.en length", frame_len, exp_wire_len.pop_front());
                    frame_len = 0;
                    frame_seen = 1'b1;
                end
                gap_len++;
            end
            wire_en_q = gmii_tx.en;
        end
    end

    // Received stream against expected beats
    always @(negedge logic_clk) begin
        if (!logic_rst && m_rx_valid && m_rx_ready) begin
            if (exp_rx.size() == 0) begin
                $display("A beat came out of m_rx with no frame expected");
                stop_on_error();
            end else begin
                rx_beat_exp = exp_rx.pop_front();
                check_value("m_rx.data", m_rx.data, rx_beat_exp[7:0]);
                check_value("m_rx.last", m_rx.last, rx_beat_exp[8]);
                check_value("m_rx.user", m_rx.user, 1'b0);
            end
        end
    end

    // Status pulse counters
    always @(negedge logic_clk) begin
        if (!logic_rst) begin
            pulse_cnt[P_TX_BAD] += tx_fifo_status.bad_frame;
            pulse_cnt[P_TX_OVER] += tx_fifo_status.overflow;
            pulse_cnt[P_TX_GOOD] += tx_fifo_status.good_frame;
            pulse_cnt[P_RX_GOOD] += rx_fifo_status.good_frame;
            pulse_cnt[P_RX_BAD] += rx_fifo_status.bad_frame;
            pulse_cnt[P_RX_OVER] += rx_fifo_status.overflow;
            pulse_cnt[P_ERR_FRAME] += rx_error_bad_frame;
            pulse_cnt[P_ERR_FCS] += rx_error_bad_fcs;
        end
    end

    initial begin
        logic_rst = 1'b1;
        s_tx = '0;
        s_tx_valid = 1'b0;
        m_rx_ready = 1'b0;
        ifg_delay = 8'd12;
        corrupt = 1'b0;
        repeat (4) @(posedge logic_clk);
        @(negedge logic_clk);
        // Outputs and pulses quiet in reset
        check_value("reset outputs", {s_tx_ready, m_rx_valid, gmii_tx.en, gmii_tx.er,
                    tx_fifo_status, rx_fifo_status, rx_error_bad_frame, rx_error_bad_fcs}, 0);
        @(posedge logic_clk);
        logic_rst <= 1'b0;
        m_rx_ready <= 1'b1;

        // Long frame, then padded short frames around the minimum
        send_frame(100, 1'b0, 1'b1);
        wait_frames_done();
        send_frame(20, 1'b0, 1'b1);
        wait_frames_done();
        send_frame(59, 1'b0, 1'b1);
        send_frame(60, 1'b0, 1'b1);
        wait_frames_done();
        expect_pulses(P_TX_GOOD, 4, "tx_fifo_status.good_frame count");
        expect_pulses(P_RX_GOOD, 4, "rx_fifo_status.good_frame count");
        expect_pulses(P_ERR_FRAME, 0, "rx_error_bad_frame count");
        expect_pulses(P_ERR_FCS, 0, "rx_error_bad_fcs count");

        // Flipped payload byte must be caught by the FCS
        corrupt <= 1'b1;
        send_frame(64, 1'b0, 1'b0);
        wait_for_count(P_RX_BAD, 1, "no rx bad frame pulse for the corrupt frame");
        wait_frames_done();
        corrupt <= 1'b0;
        expect_pulses(P_ERR_FCS, 1, "rx_error_bad_fcs count");
        expect_pulses(P_ERR_FRAME, 0, "rx_error_bad_frame count");
        expect_pulses(P_RX_GOOD, 4, "rx_fifo_status.good_frame count");
        expect_pulses(P_RX_BAD, 1, "rx_fifo_status.bad_frame count");

        // Aborted tx frame never reaches the wire
        send_frame(30, 1'b1, 1'b0);
        wait_for_count(P_TX_BAD, 1, "no tx bad frame pulse for the aborted frame");

        // Back to back with a long gap, rx held off so the fourth frame cannot fit
        ifg_delay <= 8'd20;
        m_rx_ready <= 1'b0;
        send_frame(80, 1'b0, 1'b1);
        send_frame(80, 1'b0, 1'b1);
        send_frame(80, 1'b0, 1'b1);
        send_frame(80, 1'b0, 1'b0);
        wait_for_count(P_RX_OVER, 1, "no rx overflow pulse with m_rx_ready low");
        m_rx_ready <= 1'b1;
        wait_frames_done();
        expect_pulses(P_RX_OVER, 1, "rx_fifo_status.overflow count");
        expect_pulses(P_RX_GOOD, 7, "rx_fifo_status.good_frame count");
        expect_pulses(P_RX_BAD, 1, "rx_fifo_status.bad_frame count");
        expect_pulses(P_TX_OVER, 0, "tx_fifo_status.overflow count");
        expect_pulses(P_TX_BAD, 1, "tx_fifo_status.bad_frame count");
        expect_pulses(P_TX_GOOD, 9, "tx_fifo_status.good_frame count");
        expect_pulses(P_ERR_FCS, 1, "rx_error_bad_fcs count");
        expect_pulses(P_ERR_FRAME, 0, "rx_error_bad_frame count");

        if (exp_wire.size() == 0 && exp_rx.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Expected bytes were left unchecked at the end of the run");
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
eth_pkg.sv
eth_frame_fifo.sv
eth_mac_tx.sv
eth_mac_rx.sv
eth_mac_fifo.sv
tb_eth_mac_fifo.sv

//--- Bender.yml
package:
  name: eth_mac_fifo

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - eth_pkg.sv
      - eth_frame_fifo.sv
      - eth_mac_tx.sv
      - eth_mac_rx.sv
      - eth_mac_fifo.sv

  # Simulation only
  - target: test
    files:
      - tb_eth_mac_fifo.sv
